//--- design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address and data widths
`define ADDR_W 32
`define WORD_W 64
`define LINE_W 256

// address split: tag | index | offset
`define OFFSET_W 5
`define INDEX_W 6
`define TAG_W 21

// cache geometry
`define SETS 64
// 64-bit words per line
`define BEATS 4

`endif

//--- design/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

  // address and data
  typedef logic [`ADDR_W-1:0] addrT;
  typedef logic [`WORD_W-1:0] wordT;
  typedef logic [`LINE_W-1:0] lineT;

  // address fields
  typedef logic [`TAG_W-1:0] tagT;
  typedef logic [`INDEX_W-1:0] indexT;

  // configuration port
  typedef logic [1:0] cfgAddrT;
  typedef logic [31:0] cfgDataT;

  // lookup controller states
  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stRefill,
    stRespond,
    stFlush
  } ctrlStateT;

endpackage

//--- design/cacheIfs.sv
`timescale 1ns/1ns

// line refill request from the controller to the memory sequencer
interface refillIf;
  import cache_pkg::*;

  // single-cycle pulse, only while no refill is outstanding
  logic start;
  // any address inside the wanted line
  addrT lineAddr;
  // single-cycle pulse, line is valid with it
  logic done;
  lineT line;

  modport ctrl (
    output start,
    output lineAddr,
    input  done,
    input  line
  );

  modport refill (
    input  start,
    input  lineAddr,
    output done,
    output line
  );

endinterface

// control bits toward the controller, event pulses back
interface cfgIf;
  logic enable;
  logic invalidate;
  logic hitEvt;
  logic missEvt;
  logic flushDone;

  modport cfg (
    output enable,
    output invalidate,
    input  hitEvt,
    input  missEvt,
    input  flushDone
  );

  modport ctrl (
    input  enable,
    input  invalidate,
    output hitEvt,
    output missEvt,
    output flushDone
  );

endinterface

//--- design/lineRam.sv
`timescale 1ns/1ns

module lineRam #(
  parameter int width = 256,
  parameter int depth = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(depth)-1:0] addr_i,
  input  logic [width-1:0]         wdata_i,
  output logic [width-1:0]         rdata_o
);

  logic [width-1:0] mem [depth];

  // single port, one access per enabled cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // output keeps the last read line
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- design/cacheCfg.sv
`timescale 1ns/1ns

module cacheCfg (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfgWe_i,
  input  cache_pkg::cfgAddrT cfgAddr_i,
  input  cache_pkg::cfgDataT cfgWdata_i,
  output cache_pkg::cfgDataT cfgRdata_o,
  cfgIf.cfg                  cfg
);
  import cache_pkg::*;

  localparam cfgAddrT CtrlReg = 2'd0;
  localparam cfgAddrT HitReg = 2'd1;
  localparam cfgAddrT MissReg = 2'd2;

  logic    enableQ;
  logic    invPending;
  cfgDataT hitCnt;
  cfgDataT missCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enableQ <= 1'b1;
      invPending <= 1'b0;
      hitCnt <= '0;
      missCnt <= '0;
    end else begin
      if (cfg.flushDone) begin
        invPending <= 1'b0;
      end
      // a fresh invalidate request wins over a finishing flush
      if (cfgWe_i && cfgAddr_i == CtrlReg) begin
        enableQ <= cfgWdata_i[0];
        if (cfgWdata_i[1]) begin
          invPending <= 1'b1;
        end
      end
      // writing a counter clears it
      if (cfgWe_i && cfgAddr_i == HitReg) begin
        hitCnt <= '0;
      end else if (cfg.hitEvt) begin
        hitCnt <= hitCnt + 1'b1;
      end
      if (cfgWe_i && cfgAddr_i == MissReg) begin
        missCnt <= '0;
      end else if (cfg.missEvt) begin
        missCnt <= missCnt + 1'b1;
      end
    end
  end

  assign cfg.enable = enableQ;
  assign cfg.invalidate = invPending;

  always_comb begin
    case (cfgAddr_i)
      CtrlReg: cfgRdata_o = {30'b0, invPending, enableQ};
      HitReg:  cfgRdata_o = hitCnt;
      MissReg: cfgRdata_o = missCnt;
      default: cfgRdata_o = '0;
    endcase
  end

endmodule

//--- design/refillUnit.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module refillUnit (
  input  logic            clk,
  input  logic            rst_n,
  refillIf.refill         rf,
  output logic            memRdValid_o,
  output cache_pkg::addrT memAddr_o,
  input  logic            memRdDataValid_i,
  input  logic            memRdLast_i,
  input  cache_pkg::wordT memRdData_i
);
  import cache_pkg::*;

  localparam int BeatW = $clog2(`BEATS);

  logic [BeatW-1:0] beatCnt;
  lineT             lineQ;
  logic             doneQ;
  logic             beatTaken;

  // a beat only counts while our request is up
  assign beatTaken = memRdValid_o && memRdDataValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdValid_o <= 1'b0;
      beatCnt <= '0;
      doneQ <= 1'b0;
    end else begin
      // done follows the last beat by one cycle
      doneQ <= beatTaken && memRdLast_i;
      if (rf.start) begin
        memRdValid_o <= 1'b1;
        beatCnt <= '0;
      end else if (beatTaken) begin
        beatCnt <= beatCnt + 1'b1;
        if (memRdLast_i) begin
          memRdValid_o <= 1'b0;
        end
      end
    end
  end

  // request address, offset cleared
  always_ff @(posedge clk) begin
    if (rf.start) begin
      memAddr_o <= {rf.lineAddr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
    end
  end

  // beat 0 lands in the lowest word
  always_ff @(posedge clk) begin
    if (beatTaken) begin
      lineQ[beatCnt*`WORD_W +: `WORD_W] <= memRdData_i;
    end
  end

  // line holds until the next refill starts
  assign rf.done = doneQ;
  assign rf.line = lineQ;

endmodule

//--- design/cacheCtrl.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cacheCtrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid_i,
  input  cache_pkg::addrT addr_i,
  output logic            addrOk_o,
  output logic            dataOk_o,
  output cache_pkg::wordT rdData_o,
  refillIf.ctrl           rf,
  cfgIf.ctrl              cfg
);
  import cache_pkg::*;

  localparam int Ways = 2;
  localparam int SelW = $clog2(`BEATS);

  ctrlStateT state;
  ctrlStateT nextState;

  // latched request
  addrT            reqAddr;
  tagT             reqTag;
  indexT           reqIndex;
  logic [SelW-1:0] wordSel;

  // tag, valid and LRU state per set
  tagT              tagArray [Ways][`SETS];
  logic [`SETS-1:0] validArray [Ways];
  // lruBits marks the victim way of each set
  logic [`SETS-1:0] lruBits;

  // way RAM access
  lineT       wayData [Ways];
  logic [1:0] wayWe;
  logic       ramEn;
  indexT      ramAddr;

  logic [1:0] wayHit;
  logic       hit;
  logic       hitWay;
  lineT       hitLine;
  logic       victim;
  logic       lookupHit;
  logic       lookupMiss;
  logic       accept;
  logic       writeLine;

  assign reqTag = reqAddr[`ADDR_W-1 -: `TAG_W];
  assign reqIndex = reqAddr[`OFFSET_W +: `INDEX_W];
  assign wordSel = reqAddr[`OFFSET_W-1 -: SelW];

  // tag compare on the latched request
  always_comb begin
    for (int w = 0; w < Ways; w++) begin
      wayHit[w] = validArray[w][reqIndex] && (tagArray[w][reqIndex] == reqTag);
    end
  end

  assign hit = |wayHit;
  assign hitWay = !wayHit[0];
  assign hitLine = wayHit[0] ? wayData[0] : wayData[1];
  assign victim = lruBits[reqIndex];

  // a disabled cache treats every lookup as a miss
  assign lookupHit = (state == stCompare) && hit && cfg.enable;
  assign lookupMiss = (state == stCompare) && !(hit && cfg.enable);

  // pending invalidate blocks new requests until the flush ran
  assign addrOk_o = ((state == stIdle) && !cfg.invalidate) || lookupHit;
  assign accept = valid_i && addrOk_o;

  // allocate only while enabled
  assign writeLine = (state == stRefill) && rf.done && cfg.enable;
  assign wayWe[0] = writeLine && !victim;
  assign wayWe[1] = writeLine && victim;

  // read with the incoming index, write with the latched one
  assign ramEn = accept || writeLine;
  assign ramAddr = writeLine ? reqIndex : addr_i[`OFFSET_W +: `INDEX_W];

  lineRam #(
    .width(`LINE_W),
    .depth(`SETS)
  ) way0Ram (
    .clk    (clk),
    .en_i   (ramEn),
    .we_i   (wayWe[0]),
    .addr_i (ramAddr),
    .wdata_i(rf.line),
    .rdata_o(wayData[0])
  );

  lineRam #(
    .width(`LINE_W),
    .depth(`SETS)
  ) way1Ram (
    .clk    (clk),
    .en_i   (ramEn),
    .we_i   (wayWe[1]),
    .addr_i (ramAddr),
    .wdata_i(rf.line),
    .rdata_o(wayData[1])
  );

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (accept) begin
          nextState = stCompare;
        end else if (cfg.invalidate) begin
          nextState = stFlush;
        end
      end
      stCompare: begin
        if (!lookupHit) begin
          nextState = stRefill;
        end else if (!accept) begin
          nextState = stIdle;
        end
      end
      stRefill: begin
        if (rf.done) begin
          nextState = stRespond;
        end
      end
      stRespond: nextState = stIdle;
      stFlush:   nextState = stIdle;
      default:   nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
      dataOk_o <= 1'b0;
    end else begin
      state <= nextState;
      dataOk_o <= lookupHit || (state == stRespond);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // word from the hitting way, or from the refilled line
  always_ff @(posedge clk) begin
    if (lookupHit) begin
      rdData_o <= hitLine[wordSel*`WORD_W +: `WORD_W];
    end else if (state == stRespond) begin
      rdData_o <= rf.line[wordSel*`WORD_W +: `WORD_W];
    end
  end

  always_ff @(posedge clk) begin
    if (writeLine) begin
      tagArray[victim][reqIndex] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < Ways; w++) begin
        validArray[w] <= '0;
      end
      lruBits <= '0;
    end else if (state == stFlush) begin
      for (int w = 0; w < Ways; w++) begin
        validArray[w] <= '0;
      end
    end else if (writeLine) begin
      validArray[victim][reqIndex] <= 1'b1;
      lruBits[reqIndex] <= !victim;
    end else if (lookupHit) begin
      // next victim is the way not just used
      lruBits[reqIndex] <= !hitWay;
    end
  end

  assign rf.start = lookupMiss;
  assign rf.lineAddr = reqAddr;

  assign cfg.hitEvt = lookupHit;
  assign cfg.missEvt = lookupMiss;
  assign cfg.flushDone = (state == stFlush);

endmodule

//--- design/cacheTop.sv
`timescale 1ns/1ns

module cacheTop (
  input  logic               clk,
  input  logic               rst_n,
  // pipeline side
  input  logic               valid_i,
  input  cache_pkg::addrT    addr_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output cache_pkg::wordT    rdData_o,
  // memory read port
  output logic               memRdValid_o,
  output cache_pkg::addrT    memAddr_o,
  input  logic               memRdDataValid_i,
  input  logic               memRdLast_i,
  input  cache_pkg::wordT    memRdData_i,
  // configuration registers
  input  logic               cfgWe_i,
  input  cache_pkg::cfgAddrT cfgAddr_i,
  input  cache_pkg::cfgDataT cfgWdata_i,
  output cache_pkg::cfgDataT cfgRdata_o
);

  refillIf rfBus ();
  cfgIf    cfgBus ();

  cacheCtrl uCtrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .addr_i   (addr_i),
    .addrOk_o (addrOk_o),
    .dataOk_o (dataOk_o),
    .rdData_o (rdData_o),
    .rf       (rfBus.ctrl),
    .cfg      (cfgBus.ctrl)
  );

  refillUnit uRefill (
    .clk              (clk),
    .rst_n            (rst_n),
    .rf               (rfBus.refill),
    .memRdValid_o     (memRdValid_o),
    .memAddr_o        (memAddr_o),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memRdData_i      (memRdData_i)
  );

  cacheCfg uCfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfgWe_i    (cfgWe_i),
    .cfgAddr_i  (cfgAddr_i),
    .cfgWdata_i (cfgWdata_i),
    .cfgRdata_o (cfgRdata_o),
    .cfg        (cfgBus.cfg)
  );

endmodule

//--- tests/cache_sva.sv
`timescale 1ns/1ns

module cacheSva (
  input logic            clk,
  input logic            rst_n,
  input logic            valid_i,
  input logic            addrOk_o,
  input logic            dataOk_o,
  input logic            memRdValid_o,
  input cache_pkg::addrT memAddr_o,
  input logic            memRdDataValid_i,
  input logic            memRdLast_i
);

  // an accept that starts no memory request is a hit, answered two cycles later
  hitTwoCycles: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(valid_i && addrOk_o, 2) && !memRdValid_o) |-> dataOk_o)
    else $error("hit response not two cycles after accept");

  // back-to-back dataOk only for pipelined hits
  dataOkPulse: assert property (@(posedge clk) disable iff (!rst_n)
    (dataOk_o && $past(dataOk_o)) |-> $past(valid_i && addrOk_o, 2))
    else $error("dataOk held without a matching accept");

  // request holds until the last beat
  memReqStable: assert property (@(posedge clk) disable iff (!rst_n)
    (memRdValid_o && !(memRdDataValid_i && memRdLast_i))
      |=> (memRdValid_o && $stable(memAddr_o)))
    else $error("memory request dropped or changed before last beat");

endmodule

bind cacheTop cacheSva sva (
  .clk              (clk),
  .rst_n            (rst_n),
  .valid_i          (valid_i),
  .addrOk_o         (addrOk_o),
  .dataOk_o         (dataOk_o),
  .memRdValid_o     (memRdValid_o),
  .memAddr_o        (memAddr_o),
  .memRdDataValid_i (memRdDataValid_i),
  .memRdLast_i      (memRdLast_i)
);

//--- tests/cache_tb.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cacheTb;
  import cache_pkg::*;

  logic    clk;
  logic    rst_n;
  logic    valid_i;
  addrT    addr_i;
  logic    addrOk_o;
  logic    dataOk_o;
  wordT    rdData_o;
  logic    memRdValid_o;
  addrT    memAddr_o;
  logic    memRdDataValid_i;
  logic    memRdLast_i;
  wordT    memRdData_i;
  logic    cfgWe_i;
  cfgAddrT cfgAddr_i;
  cfgDataT cfgWdata_i;
  cfgDataT cfgRdata_o;

  int    errors = 0;
  int    checks = 0;
  string curTest = "reset";
  int    memReqCount = 0;
  addrT  lastMemAddr;
  logic [31:0] lfsrState = 32'hac2d76cd;

  // reference cache state
  tagT  refTag [2][`SETS];
  logic refValid [2][`SETS];
  logic refLru [`SETS];
  logic refEnable;

  cacheTop dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #2000000;
    $display("simulation did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic lfsrStep();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic int randBits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsrStep());
    end
    return v;
  endfunction

  // memory content rule
  function automatic wordT memWord(addrT a);
    return {~a, a ^ 32'h3c96a5f1};
  endfunction

  // predicts hit or miss and updates the model like an allocating access
  function automatic logic refAccess(addrT a);
    tagT  t;
    int   idx;
    logic h;
    int   w;
    t = a[`ADDR_W-1 -: `TAG_W];
    idx = int'(a[`OFFSET_W +: `INDEX_W]);
    h = 1'b0;
    w = 0;
    if (!refEnable) begin
      return 1'b0;
    end
    for (int i = 0; i < 2; i++) begin
      if (refValid[i][idx] && refTag[i][idx] == t) begin
        h = 1'b1;
        w = i;
      end
    end
    if (!h) begin
      w = int'(refLru[idx]);
      refTag[w][idx] = t;
      refValid[w][idx] = 1'b1;
    end
    // victim becomes the way not just used
    refLru[idx] = (w == 0);
    return h;
  endfunction

  function automatic void refFlush();
    for (int s = 0; s < `SETS; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
    end
  endfunction

  // memory model, 0 to 2 idle cycles before each beat
  initial begin : memModel
    int   gap;
    addrT base;
    memRdDataValid_i = 1'b0;
    memRdLast_i = 1'b0;
    memRdData_i = '0;
    forever begin
      @(negedge clk);
      if (memRdValid_o === 1'b1) begin
        memReqCount++;
        base = memAddr_o;
        lastMemAddr = memAddr_o;
        for (int b = 0; b < `BEATS; b++) begin
          gap = randBits(2) % 3;
          repeat (gap) @(negedge clk);
          memRdDataValid_i = 1'b1;
          memRdData_i = memWord(base + 32'(b * 8));
          memRdLast_i = (b == `BEATS - 1);
          @(negedge clk);
          memRdDataValid_i = 1'b0;
          memRdLast_i = 1'b0;
        end
      end
    end
  end

  task automatic reportMismatch(string what, logic [63:0] exp, logic [63:0] act);
    errors++;
    $display("Error %s: %s expected %h actual %h", curTest, what, exp, act);
  endtask

  task automatic reportFail(string msg);
    errors++;
    $display("%s: %s", curTest, msg);
  endtask

  task automatic cfgWrite(cfgAddrT a, cfgDataT d);
    @(negedge clk);
    cfgWe_i = 1'b1;
    cfgAddr_i = a;
    cfgWdata_i = d;
    @(negedge clk);
    cfgWe_i = 1'b0;
  endtask

  task automatic cfgCheck(cfgAddrT a, cfgDataT exp, string what);
    @(negedge clk);
    cfgAddr_i = a;
    @(negedge clk);
    checks++;
    if (cfgRdata_o !== exp) begin
      reportMismatch(what, 64'(exp), 64'(cfgRdata_o));
    end
  endtask

  // one read, checked for data, latency and memory traffic
  task automatic readCheck(addrT a);
    logic expHit;
    int   reqBefore;
    int   lat;
    int   n;
    wordT expData;
    expHit = refAccess(a);
    reqBefore = memReqCount;
    expData = memWord({a[`ADDR_W-1:3], 3'b000});
    checks++;
    @(negedge clk);
    valid_i = 1'b1;
    addr_i = a;
    n = 0;
    while (addrOk_o !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (addrOk_o !== 1'b1) begin
      reportFail($sformatf("request for %h was never accepted", a));
      valid_i = 1'b0;
      return;
    end
    @(posedge clk);
    @(negedge clk);
    valid_i = 1'b0;
    lat = 1;
    while (dataOk_o !== 1'b1 && lat < 200) begin
      @(negedge clk);
      lat++;
    end
    if (dataOk_o !== 1'b1) begin
      reportFail($sformatf("no response for read of %h", a));
    end else begin
      if (rdData_o !== expData) begin
        reportMismatch("read data", expData, rdData_o);
      end
      if (expHit) begin
        if (lat != 2) begin
          reportMismatch("hit latency", 64'(2), 64'(lat));
        end
        if (memReqCount != reqBefore) begin
          reportFail($sformatf("hit on %h caused a memory request", a));
        end
      end else if (memReqCount != reqBefore + 1) begin
        reportMismatch("memory requests", 64'(reqBefore + 1), 64'(memReqCount));
      end else if (lastMemAddr !== {a[`ADDR_W-1:`OFFSET_W], 5'b0}) begin
        reportMismatch("refill address", 64'({a[`ADDR_W-1:`OFFSET_W], 5'b0}),
                       64'(lastMemAddr));
      end
    end
  endtask

  task automatic coldMissThenHit();
    curTest = "cold miss then hit";
    readCheck(32'h0000_1008);
    readCheck(32'h0000_1008);
    cfgCheck(2'd1, 32'd1, "hit count");
    cfgCheck(2'd2, 32'd1, "miss count");
  endtask

  task automatic wordSelect();
    curTest = "word select";
    for (int off = 0; off < 32; off += 8) begin
      readCheck(32'h0000_1000 + 32'(off));
    end
  endtask

  // three tags in set 2
  task automatic lruEvict();
    curTest = "two-way LRU";
    readCheck(32'h0001_0040);
    readCheck(32'h0001_0840);
    readCheck(32'h0001_0040);
    readCheck(32'h0001_1040);
    readCheck(32'h0001_0040);
    readCheck(32'h0001_0840);
  endtask

  task automatic backToBack();
    addrT addrs [4];
    int   issued;
    int   got;
    int   cyc;
    int   firstAt;
    int   lastAt;
    int   reqBefore;
    logic acceptNext;
    curTest = "back-to-back hits";
    addrs = '{32'h0000_1018, 32'h0000_1000, 32'h0000_1010, 32'h0000_1008};
    for (int i = 0; i < 4; i++) begin
      if (!refAccess(addrs[i])) begin
        reportFail("line not resident before back-to-back reads");
      end
    end
    reqBefore = memReqCount;
    issued = 0;
    got = 0;
    cyc = 0;
    firstAt = -1;
    lastAt = -1;
    @(negedge clk);
    valid_i = 1'b1;
    addr_i = addrs[0];
    while (addrOk_o !== 1'b1 && cyc < 100) begin
      @(negedge clk);
      cyc++;
    end
    cyc = 0;
    while (got < 4 && cyc < 50) begin
      acceptNext = valid_i && addrOk_o;
      @(negedge clk);
      cyc++;
      if (acceptNext) begin
        issued++;
      end
      if (dataOk_o === 1'b1) begin
        checks++;
        if (rdData_o !== memWord(addrs[got])) begin
          reportMismatch("read data", memWord(addrs[got]), rdData_o);
        end
        if (firstAt < 0) begin
          firstAt = cyc;
        end
        lastAt = cyc;
        got++;
      end
      if (issued < 4) begin
        addr_i = addrs[issued];
        if (addrOk_o !== 1'b1) begin
          reportFail("next request not accepted during a hit");
        end
      end else begin
        valid_i = 1'b0;
      end
    end
    valid_i = 1'b0;
    if (got != 4) begin
      reportFail($sformatf("only %0d of 4 responses arrived", got));
    end else if (lastAt - firstAt != 3) begin
      reportMismatch("response span", 64'(3), 64'(lastAt - firstAt));
    end
    if (memReqCount != reqBefore) begin
      reportFail("back-to-back hits caused a memory request");
    end
  endtask

  task automatic disableInvalidate();
    int n;
    curTest = "disable and invalidate";
    cfgWrite(2'd0, 32'd0);
    refEnable = 1'b0;
    cfgWrite(2'd2, 32'd0);
    readCheck(32'h0000_1008);
    readCheck(32'h0000_1008);
    cfgCheck(2'd2, 32'd2, "miss count while disabled");
    // enable again and request a flush
    cfgWrite(2'd0, 32'd3);
    refEnable = 1'b1;
    cfgAddr_i = 2'd0;
    n = 0;
    @(negedge clk);
    while (cfgRdata_o[1] !== 1'b0 && n < 100) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (cfgRdata_o[1] !== 1'b0) begin
      reportFail("invalidate bit never cleared");
    end
    refFlush();
    readCheck(32'h0000_1008);
    readCheck(32'h0000_1008);
  endtask

  initial begin
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    cfgWe_i = 1'b0;
    cfgAddr_i = '0;
    cfgWdata_i = '0;
    refEnable = 1'b1;
    for (int s = 0; s < `SETS; s++) begin
      refLru[s] = 1'b0;
    end
    refFlush();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    coldMissThenHit();
    wordSelect();
    lruEvict();
    backToBack();
    disableInvalidate();

    repeat (4) @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+design
design/cache_pkg.sv
design/cacheIfs.sv
design/lineRam.sv
design/cacheCfg.sv
design/refillUnit.sv
design/cacheCtrl.sv
design/cacheTop.sv
tests/cache_sva.sv
tests/cache_tb.sv

//--- Makefile
.PHONY: sim clean

# a crash or an assertion stop also counts as a failure
sim:
	verilator --binary --timing --assert -f sim.f --top-module cacheTb -Mdir obj_dir
	./obj_dir/VcacheTb > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
